// File: Bender.yml
package:
  name: core

sources:
  - rtl/core_pkg.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/mem_stage.sv
  - rtl/core_top.sv
  - target: test
    files:
      - tests/core_sva.sv
      - tests/core_tb.sv

// File: project.f
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/core_top.sv
tests/core_sva.sv
tests/core_tb.sv

// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int num_regs = 16;

    // Instruction word field positions
    localparam int opc_msb = 31;
    localparam int opc_lsb = 28;
    localparam int rd_msb  = 27;
    localparam int rd_lsb  = 24;
    localparam int rs1_msb = 23;
    localparam int rs1_lsb = 20;
    localparam int rs2_msb = 19;
    localparam int rs2_lsb = 16;
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;

    typedef logic [3:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_and   = 4'd3,
        op_or    = 4'd4,
        op_addi  = 4'd5,
        op_load  = 4'd6,
        op_store = 4'd7  // Highest defined code
    } opcode_e;

    typedef struct packed {
        opcode_e  op;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm;    // Already sign-extended
        logic     valid;
    } uop_t;

    typedef struct packed {
        opcode_e  op;
        reg_idx_t rd;
        word_t    value;  // ALU result or effective address
        word_t    store_data;
        logic     valid;
    } ex_result_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     wr_en;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    // ALU ops and loads update a register
    function automatic logic writes_rd(opcode_e op);
        return (op inside {op_add, op_sub, op_and, op_or, op_addi, op_load});
    endfunction

endpackage

`default_nettype wire

// File: rtl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  core_pkg::word_t    instr,
    output logic               instr_ack,
    output logic               dmem_req,
    output core_pkg::mem_req_t dmem,
    input  logic               dmem_ack,
    input  core_pkg::word_t    dmem_rdata,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);

    core_pkg::reg_idx_t   rs1;
    core_pkg::reg_idx_t   rs2;
    core_pkg::word_t      rd1;
    core_pkg::word_t      rd2;
    core_pkg::uop_t       uop;
    core_pkg::ex_result_t ex;
    logic                 mem_busy;

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd1      (rd1),
        .rd2      (rd2),
        .wr       (retire),
        .wr_valid (retire_valid)
    );

    decode_stage i_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_req    (instr_req),
        .instr        (instr),
        .instr_ack    (instr_ack),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd1          (rd1),
        .rd2          (rd2),
        .stall        (mem_busy),
        .retire       (retire),
        .retire_valid (retire_valid),
        .uop          (uop)
    );

    execute_stage i_execute (
        .clk    (clk),
        .rst    (rst),
        .uop    (uop),
        .stall  (mem_busy),
        .result (ex)
    );

    mem_stage i_mem (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex),
        .busy         (mem_busy),
        .dmem_req     (dmem_req),
        .dmem         (dmem),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  core_pkg::word_t    instr,
    output logic               instr_ack,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    input  core_pkg::word_t    rd1,
    input  core_pkg::word_t    rd2,
    input  logic               stall,
    input  core_pkg::retire_t  retire,
    input  logic               retire_valid,
    output core_pkg::uop_t     uop
);

    typedef enum logic {dec_idle, dec_acked} decode_state_e;

    decode_state_e                 state;
    core_pkg::word_t               ir;
    logic                          ir_valid;
    core_pkg::opcode_e             in_op;
    core_pkg::opcode_e             ir_op;
    core_pkg::reg_idx_t            in_rd;
    core_pkg::reg_idx_t            in_rs1;
    core_pkg::reg_idx_t            in_rs2;
    logic [core_pkg::num_regs-1:0] pending;
    logic [core_pkg::num_regs-1:0] clr_mask;
    logic [core_pkg::num_regs-1:0] set_mask;
    logic [core_pkg::num_regs-1:0] live_mask;
    logic                          hazard;
    logic                          issue;

    // Codes above store are unused and fold to nop
    function automatic core_pkg::opcode_e to_op(logic [3:0] code);
        if (code <= core_pkg::op_store)
            return core_pkg::opcode_e'(code);
        return core_pkg::op_nop;
    endfunction

    assign in_op  = to_op(instr[core_pkg::opc_msb:core_pkg::opc_lsb]);
    assign in_rd  = instr[core_pkg::rd_msb:core_pkg::rd_lsb];
    assign in_rs1 = instr[core_pkg::rs1_msb:core_pkg::rs1_lsb];
    assign in_rs2 = instr[core_pkg::rs2_msb:core_pkg::rs2_lsb];
    assign ir_op  = to_op(ir[core_pkg::opc_msb:core_pkg::opc_lsb]);

    // Operand reads happen the cycle after the instruction is latched
    assign rs1 = ir[core_pkg::rs1_msb:core_pkg::rs1_lsb];
    assign rs2 = ir[core_pkg::rs2_msb:core_pkg::rs2_lsb];

    assign clr_mask  = (retire_valid && retire.wr_en) ?
                       (core_pkg::num_regs)'(1) << retire.rd : '0;
    assign live_mask = pending & ~clr_mask;  // Retiring writer no longer blocks
    assign hazard    = live_mask[in_rs1] | live_mask[in_rs2] | live_mask[in_rd];
    assign issue     = instr_req && state == dec_idle && !ir_valid && !stall && !hazard;
    assign set_mask  = (issue && core_pkg::writes_rd(in_op)) ?
                       (core_pkg::num_regs)'(1) << in_rd : '0;

    assign instr_ack = (state == dec_acked);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= dec_idle;
            pending  <= '0;
            ir       <= '0;
            ir_valid <= 1'b0;
        end
        else
        begin
            pending <= live_mask | set_mask;  // Set wins over clear
            case (state)
                dec_idle:  if (issue) state <= dec_acked;
                dec_acked: if (!instr_req) state <= dec_idle;  // Source released
                default:   state <= dec_idle;
            endcase
            if (issue)
            begin
                ir       <= instr;
                ir_valid <= 1'b1;
            end
            else if (!stall)
            begin
                ir_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            uop <= '0;
        end
        else if (!stall)
        begin
            uop.valid <= ir_valid && (ir_op != core_pkg::op_nop);  // Nops go no further
            uop.op    <= ir_op;
            uop.rd    <= ir[core_pkg::rd_msb:core_pkg::rd_lsb];
            uop.a     <= rd1;
            uop.b     <= rd2;
            uop.imm   <= {{16{ir[core_pkg::imm_msb]}}, ir[core_pkg::imm_msb:core_pkg::imm_lsb]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::uop_t       uop,
    input  logic                 stall,
    output core_pkg::ex_result_t result
);

    core_pkg::word_t alu;

    always_comb
    begin
        case (uop.op)
            core_pkg::op_add:
                alu = uop.a + uop.b;
            core_pkg::op_sub:
                alu = uop.a - uop.b;
            core_pkg::op_and:
                alu = uop.a & uop.b;
            core_pkg::op_or:
                alu = uop.a | uop.b;
            core_pkg::op_addi, core_pkg::op_load, core_pkg::op_store:
                alu = uop.a + uop.imm;  // Also the effective address
            default:
                alu = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result <= '0;
        end
        else if (!stall)  // Hold while memory is busy
        begin
            result.valid      <= uop.valid;
            result.op         <= uop.op;
            result.rd         <= uop.rd;
            result.value      <= alu;
            result.store_data <= uop.b;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::ex_result_t ex,
    output logic                 busy,
    output logic                 dmem_req,
    output core_pkg::mem_req_t   dmem,
    input  logic                 dmem_ack,
    input  core_pkg::word_t      dmem_rdata,
    output logic                 retire_valid,
    output core_pkg::retire_t    retire
);

    typedef enum logic [1:0] {
        mem_idle,
        mem_req,
        mem_release,
        mem_done
    } mem_state_e;

    mem_state_e         state;
    core_pkg::reg_idx_t rd_q;
    logic               load_q;
    logic               is_mem_op;

    assign is_mem_op = (ex.op == core_pkg::op_load) || (ex.op == core_pkg::op_store);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= mem_idle;
            busy         <= 1'b0;
            dmem_req     <= 1'b0;
            dmem         <= '0;
            retire_valid <= 1'b0;
            retire       <= '0;
            rd_q         <= '0;
            load_q       <= 1'b0;
        end
        else
        begin
            retire_valid <= 1'b0;  // Single-cycle pulse
            case (state)
                // Retire cycle of a memory op also accepts the next result
                mem_idle, mem_done:
                begin
                    state <= mem_idle;
                    if (ex.valid && is_mem_op)
                    begin
                        dmem.addr  <= ex.value;
                        dmem.wdata <= ex.store_data;
                        dmem.write <= (ex.op == core_pkg::op_store);
                        dmem_req   <= 1'b1;
                        busy       <= 1'b1;
                        rd_q       <= ex.rd;
                        load_q     <= (ex.op == core_pkg::op_load);
                        state      <= mem_req;
                    end
                    else if (ex.valid)
                    begin
                        retire_valid <= 1'b1;  // ALU result goes straight out
                        retire.rd    <= ex.rd;
                        retire.data  <= ex.value;
                        retire.wr_en <= core_pkg::writes_rd(ex.op);
                    end
                end
                mem_req:
                begin
                    if (dmem_ack)
                    begin
                        retire.data <= load_q ? dmem_rdata : dmem.wdata;
                        dmem_req    <= 1'b0;
                        state       <= mem_release;
                    end
                end
                mem_release:
                begin
                    if (!dmem_ack)  // Memory finished its half of the handshake
                    begin
                        retire_valid <= 1'b1;
                        retire.rd    <= rd_q;
                        retire.wr_en <= load_q;  // Stores write nothing back
                        busy         <= 1'b0;
                        state        <= mem_done;
                    end
                end
                default:
                    state <= mem_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2,
    input  core_pkg::retire_t  wr,
    input  logic               wr_valid
);

    core_pkg::word_t regs [core_pkg::num_regs];
    logic            we;

    assign we = wr_valid && wr.wr_en && (wr.rd != '0);  // r0 never written

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < core_pkg::num_regs; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through so a reader in the retire cycle sees the new value
    assign rd1 = (we && wr.rd == rs1) ? wr.data : regs[rs1];
    assign rd2 = (we && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

`default_nettype wire

// File: tests/core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module core_sva (
    input logic               clk,
    input logic               rst,
    input logic               instr_req,
    input logic               instr_ack,
    input logic               dmem_req,
    input core_pkg::mem_req_t dmem,
    input logic               dmem_ack,
    input logic               retire_valid,
    input core_pkg::retire_t  retire
);

    int fail_count = 0;

    req_held: assert property (@(posedge clk) disable iff (rst)
        instr_req && !instr_ack |=> instr_req)
    else
    begin
        $error("instr_req fell before instr_ack rose");
        fail_count++;
    end

    // Request payload frozen for the whole transaction
    dmem_stable: assert property (@(posedge clk) disable iff (rst)
        dmem_req && $past(dmem_req) |-> $stable(dmem))
    else
    begin
        $error("dmem changed while dmem_req was high");
        fail_count++;
    end

    dmem_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(dmem_req) |-> !dmem_ack)
    else
    begin
        $error("dmem_req rose while dmem_ack was high");
        fail_count++;
    end

    r0_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid && retire.wr_en && retire.rd == '0
        |=> !(retire_valid && retire.wr_en && retire.rd == '0))
    else
    begin
        $error("two r0 writes retired in consecutive cycles");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: tests/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    typedef struct packed {
        core_pkg::retire_t rec;
        logic [31:0]       ack_cycle;
        logic              chk_lat;  // Independent ALU op, fixed latency
    } expect_t;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               instr_req = 1'b0;
    core_pkg::word_t    instr = '0;
    logic               instr_ack;
    logic               dmem_req;
    core_pkg::mem_req_t dmem;
    logic               dmem_ack = 1'b0;
    core_pkg::word_t    dmem_rdata = '0;
    logic               retire_valid;
    core_pkg::retire_t  retire;

    core_pkg::word_t model_regs [16];
    core_pkg::word_t model_mem [256];
    core_pkg::word_t resp_mem [256];
    expect_t         exp_q [$];
    logic [31:0]     rng = 32'h4e30_dfe4;
    logic [31:0]     cycle = '0;
    int              errors = 0;
    int              in_flight = 0;
    int              fixed_delay = -1;  // Negative means random ack delay
    int              wait_cnt = -1;

    core_top i_dut (.*);

    bind core_top core_sva i_sva (.*);

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] next_rand(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic core_pkg::word_t fill_word(int i);
        return 32'hc0de_0000 ^ (32'(i) * 32'h0001_0003);
    endfunction

    function automatic core_pkg::word_t encode(core_pkg::opcode_e op, logic [3:0] rd,
                                               logic [3:0] rs1, logic [3:0] rs2,
                                               logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic finish_run();
        int total;
        total = errors + i_dut.i_sva.fail_count;
        $display("errors: %0d checks, %0d assertions", errors, i_dut.i_sva.fail_count);
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic report_mismatch(string name, core_pkg::word_t exp, core_pkg::word_t got);
        errors++;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic timeout_abort(string what);
        errors++;
        $display("FAIL t=%0t timeout: %s", $time, what);
        finish_run();
    endtask

    // Word-addressed data memory, 32-bit accesses only
    always @(posedge clk)
    begin
        if (rst)
        begin
            dmem_ack <= 1'b0;
            wait_cnt <= -1;
        end
        else if (dmem_req && !dmem_ack)
        begin
            if (wait_cnt < 0)
            begin
                rng = next_rand(rng);
                wait_cnt <= (fixed_delay >= 0) ? fixed_delay : int'(rng % 32'd6);
            end
            else if (wait_cnt == 0)
            begin
                dmem_ack   <= 1'b1;
                dmem_rdata <= resp_mem[dmem.addr[9:2]];
                if (dmem.write)
                    resp_mem[dmem.addr[9:2]] = dmem.wdata;
                wait_cnt   <= -1;
            end
            else
                wait_cnt <= wait_cnt - 1;
        end
        else if (!dmem_req && dmem_ack)
            dmem_ack <= 1'b0;
    end

    always @(negedge clk)
    begin
        expect_t e;
        if (!rst && retire_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("FAIL t=%0t retire seen with no instruction outstanding", $time);
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                in_flight--;
                assert (retire.rd == e.rec.rd)
                else report_mismatch("retire.rd", e.rec.rd, retire.rd);
                assert (retire.wr_en == e.rec.wr_en)
                else report_mismatch("retire.wr_en", e.rec.wr_en, retire.wr_en);
                assert (!e.rec.wr_en || retire.data == e.rec.data)
                else report_mismatch("retire.data", e.rec.data, retire.data);
                assert (!e.chk_lat || cycle - e.ack_cycle == 3)
                else report_mismatch("retire latency", 3, cycle - e.ack_cycle);
            end
        end
    end

    task automatic issue_instr(core_pkg::word_t w, logic chk_lat);
        core_pkg::opcode_e op;
        logic [3:0]        rd;
        core_pkg::word_t   a;
        core_pkg::word_t   b;
        core_pkg::word_t   addr;
        core_pkg::word_t   res;
        logic              wr;
        expect_t           e;
        int                t;
        op   = core_pkg::opcode_e'(w[31:28]);
        rd   = w[27:24];
        a    = model_regs[w[23:20]];
        b    = model_regs[w[19:16]];
        addr = a + {{16{w[15]}}, w[15:0]};
        wr   = op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                          core_pkg::op_or, core_pkg::op_addi, core_pkg::op_load};
        case (op)
            core_pkg::op_add:   res = a + b;
            core_pkg::op_sub:   res = a - b;
            core_pkg::op_and:   res = a & b;
            core_pkg::op_or:    res = a | b;
            core_pkg::op_addi:  res = addr;
            core_pkg::op_load:  res = model_mem[addr[9:2]];
            default:            res = b;  // Store data
        endcase
        @(posedge clk);
        instr_req <= 1'b1;
        instr     <= w;
        t = 0;
        do
        begin
            @(negedge clk);
            t++;
        end
        while (!instr_ack && t < 100);
        assert (instr_ack) else timeout_abort("instruction never acknowledged");
        e.rec.rd    = rd;
        e.rec.data  = res;
        e.rec.wr_en = wr;
        e.ack_cycle = cycle;
        e.chk_lat   = chk_lat;
        exp_q.push_back(e);
        in_flight++;
        assert (in_flight <= 3)
        else report_mismatch("instructions in flight", 3, in_flight);
        if (op == core_pkg::op_store)
            model_mem[addr[9:2]] = b;
        if (wr && rd != 0)
            model_regs[rd] = res;
        @(posedge clk);
        instr_req <= 1'b0;
        t = 0;
        do
        begin
            @(negedge clk);
            t++;
        end
        while (instr_ack && t < 100);
        assert (!instr_ack) else timeout_abort("instr_ack never fell");
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 300)
        begin
            @(negedge clk);
            t++;
        end
        assert (exp_q.size() == 0) else timeout_abort("instructions never retired");
    endtask

    task automatic check_mem_word(core_pkg::word_t addr);
        assert (resp_mem[addr[9:2]] == model_mem[addr[9:2]])
        else report_mismatch("dmem word", model_mem[addr[9:2]], resp_mem[addr[9:2]]);
    endtask

    task automatic alu_ops();
        logic [3:0] code;
        issue_instr(encode(core_pkg::op_addi, 4'd1, 4'd0, 4'd0, 16'd5), 1'b1);
        issue_instr(encode(core_pkg::op_addi, 4'd2, 4'd0, 4'd0, 16'hfffd), 1'b1);
        issue_instr(encode(core_pkg::op_add, 4'd3, 4'd1, 4'd2, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_sub, 4'd4, 4'd1, 4'd2, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_and, 4'd5, 4'd2, 4'd4, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_or, 4'd6, 4'd1, 4'd2, 16'd0), 1'b1);
        for (int i = 0; i < 8; i++)
        begin
            rng  = next_rand(rng);
            code = 4'd1 + 4'(rng[30:28] % 3'd5);  // add through addi
            issue_instr({code, rng[27:0]}, 1'b1);
        end
        wait_drain();
    endtask

    task automatic dependent_ops();
        issue_instr(encode(core_pkg::op_addi, 4'd4, 4'd0, 4'd0, 16'd7), 1'b1);
        issue_instr(encode(core_pkg::op_add, 4'd5, 4'd4, 4'd4, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_sub, 4'd6, 4'd5, 4'd4, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_addi, 4'd0, 4'd5, 4'd0, 16'd9), 1'b1);  // r0 stays 0
        issue_instr(encode(core_pkg::op_add, 4'd7, 4'd0, 4'd5, 16'd0), 1'b1);
        issue_instr(encode(core_pkg::op_or, 4'd8, 4'd0, 4'd0, 16'd0), 1'b1);
        wait_drain();
    endtask

    task automatic store_then_load();
        issue_instr(encode(core_pkg::op_addi, 4'd9, 4'd0, 4'd0, 16'd64), 1'b1);
        rng = next_rand(rng);
        issue_instr(encode(core_pkg::op_addi, 4'd10, 4'd0, 4'd0, rng[15:0]), 1'b1);
        issue_instr(encode(core_pkg::op_store, 4'd0, 4'd9, 4'd10, 16'd8), 1'b0);
        rng = next_rand(rng);
        issue_instr(encode(core_pkg::op_addi, 4'd10, 4'd0, 4'd0, rng[15:0]), 1'b0);
        issue_instr(encode(core_pkg::op_store, 4'd0, 4'd9, 4'd10, 16'hfffc), 1'b0);
        issue_instr(encode(core_pkg::op_store, 4'd0, 4'd9, 4'd3, 16'd256), 1'b0);
        issue_instr(encode(core_pkg::op_load, 4'd11, 4'd9, 4'd0, 16'd8), 1'b0);
        issue_instr(encode(core_pkg::op_load, 4'd12, 4'd9, 4'd0, 16'hfffc), 1'b0);
        issue_instr(encode(core_pkg::op_load, 4'd13, 4'd9, 4'd0, 16'd256), 1'b0);
        issue_instr(encode(core_pkg::op_load, 4'd14, 4'd9, 4'd0, 16'd32), 1'b0);  // Fill value
        wait_drain();
        check_mem_word(32'd72);
        check_mem_word(32'd60);
        check_mem_word(32'd320);
    endtask

    task automatic mem_backpressure();
        fixed_delay = 12;
        issue_instr(encode(core_pkg::op_load, 4'd13, 4'd9, 4'd0, 16'd8), 1'b0);
        // Independent of the load, so only the stall can hold them back
        issue_instr(encode(core_pkg::op_addi, 4'd1, 4'd0, 4'd0, 16'd1), 1'b0);
        issue_instr(encode(core_pkg::op_addi, 4'd2, 4'd0, 4'd0, 16'd2), 1'b0);
        issue_instr(encode(core_pkg::op_addi, 4'd3, 4'd0, 4'd0, 16'd3), 1'b0);
        issue_instr(encode(core_pkg::op_or, 4'd4, 4'd3, 4'd13, 16'd0), 1'b0);
        issue_instr(encode(core_pkg::op_sub, 4'd5, 4'd4, 4'd1, 16'd0), 1'b0);
        wait_drain();
        fixed_delay = -1;
    endtask

    task automatic reset_mid_load();
        int t;
        fixed_delay = 20;
        issue_instr(encode(core_pkg::op_load, 4'd11, 4'd9, 4'd0, 16'd8), 1'b0);
        t = 0;
        while (!dmem_req && t < 50)
        begin
            @(negedge clk);
            t++;
        end
        assert (dmem_req) else timeout_abort("load never reached the data memory port");
        @(posedge clk);
        rst       <= 1'b1;
        instr_req <= 1'b0;
        @(negedge clk);
        assert (!instr_ack) else report_mismatch("instr_ack", 0, instr_ack);
        assert (!dmem_req) else report_mismatch("dmem_req", 0, dmem_req);
        assert (!retire_valid) else report_mismatch("retire_valid", 0, retire_valid);
        exp_q.delete();
        in_flight = 0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        fixed_delay = -1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int r = 1; r < 16; r++)
            issue_instr(encode(core_pkg::op_add, 4'(r), 4'(r), 4'(r), 16'd0), 1'b1);
        wait_drain();
    endtask

    initial
    begin
        for (int i = 0; i < 256; i++)
        begin
            model_mem[i] = fill_word(i);
            resp_mem[i]  = fill_word(i);
        end
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        alu_ops();
        dependent_ops();
        store_then_load();
        mem_backpressure();
        reset_mid_load();
        finish_run();
    end

endmodule

`default_nettype wire
